//--- ni_pkg.sv
// Shared widths, channel codes and flit layout of the network interface
// Every local channel is single beat, responses return in order per channel
// Payloads narrower than PayloadWidth ride zero-extended in the flit
`default_nettype none

package ni_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned TxnIdWidth   = 4;
  localparam int unsigned NodeIdWidth  = 4;
  // Destination node sits in the top nibble of the address
  localparam int unsigned NodeIdOffset = 28;
  localparam int unsigned PayloadWidth = 68;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [TxnIdWidth-1:0]   txn_id_t;
  typedef logic [NodeIdWidth-1:0]  node_id_t;
  typedef logic [1:0]              resp_t;
  typedef logic [PayloadWidth-1:0] payload_t;

  localparam resp_t RespOkay   = 2'd0;
  localparam resp_t RespSlvErr = 2'd2;

  typedef enum logic [1:0] {
    ChWr = 2'd0,
    ChRd = 2'd1,
    ChB  = 2'd2,
    ChR  = 2'd3
  } ni_ch_e;

  typedef struct packed {
    node_id_t dst_id;
    node_id_t src_id;
    ni_ch_e   ch;
  } hdr_t;

  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

  //////////////////////////////
  // Local manager channels
  //////////////////////////////

  // Single-beat write, address and data travel together
  typedef struct packed {
    addr_t   addr;
    data_t   data;
    txn_id_t id;
  } wr_req_t;

  typedef struct packed {
    addr_t   addr;
    txn_id_t id;
  } rd_req_t;

  typedef struct packed {
    txn_id_t id;
    resp_t   resp;
  } b_rsp_t;

  typedef struct packed {
    txn_id_t id;
    data_t   data;
    resp_t   resp;
  } r_rsp_t;

  //////////////////////////////
  // Local memory channels
  //////////////////////////////

  // No ID on the memory side, the meta buffers keep it
  typedef struct packed {
    addr_t addr;
    data_t data;
  } mem_wr_t;

  typedef struct packed {
    addr_t addr;
  } mem_rd_t;

  typedef struct packed {
    resp_t resp;
  } mem_b_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } mem_r_t;

  // Per-transaction state kept until the memory answers
  typedef struct packed {
    txn_id_t  id;
    node_id_t src_id;
  } meta_t;

endpackage

`default_nettype wire

//--- ni_spill_reg.sv
// Two-entry spill register, ready_o and data_o both come from flops
// First data leaves one cycle after it is taken in
// A steady flow passes at one item per cycle
`timescale 1ns/1ps
`default_nettype none

module ni_spill_reg #(
  parameter int unsigned Width = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  // Slot A takes new data, slot B parks the older item on a stall
  logic             a_full_q, b_full_q;
  logic [Width-1:0] a_data_q, b_data_q;
  logic             a_fill, a_drain, b_fill, b_drain;

  assign ready_o = !a_full_q || !b_full_q;
  assign a_fill  = valid_i && ready_o;
  // A empties whenever B is free, either to the output or into B
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Stalled output keeps its item across the move from A to B
  assert_hold_data : assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

//--- ni_rr_arbiter.sv
// Two-input round-robin arbiter with a data mux
// Grant is combinational from valid_i, priority flips past each winner
`timescale 1ns/1ps
`default_nettype none

module ni_rr_arbiter #(
  parameter int unsigned Width = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [1:0]            valid_i,
  output logic [1:0]            ready_o,
  input  logic [1:0][Width-1:0] data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic [Width-1:0]      data_o
);

  // Input that wins when both request
  logic prio_q;
  logic sel;

  assign sel     = valid_i[prio_q] ? prio_q : !prio_q;
  assign valid_o = |valid_i;
  assign data_o  = data_i[sel];

  always_comb begin
    ready_o      = 2'b00;
    ready_o[sel] = valid_i[sel] && ready_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= 1'b0;
    end else if (valid_o) begin
      // A stalled winner keeps its grant, a transfer passes priority on
      prio_q <= ready_i ? !sel : sel;
    end
  end

  // Stalled output keeps its item while the inputs hold theirs
  assert_hold_grant : assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

//--- ni_mgr_side.sv
// Manager half of the network interface
// Destination node is a fixed address field, there is no address map
// Responses are steered by channel code and pass in arrival order
`timescale 1ns/1ps
`default_nettype none

module ni_mgr_side (
  input  logic             clk_i,
  input  logic             reset_i,
  input  ni_pkg::node_id_t id_i,
  // Local requests, already cut by the input spill registers
  input  ni_pkg::wr_req_t  wr_req_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  input  ni_pkg::rd_req_t  rd_req_i,
  input  logic             rd_valid_i,
  output logic             rd_ready_o,
  // Local responses
  output ni_pkg::b_rsp_t   b_rsp_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  output ni_pkg::r_rsp_t   r_rsp_o,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  // Outbound request link
  output ni_pkg::flit_t    req_flit_o,
  output logic             req_valid_o,
  input  logic             req_ready_i,
  // Inbound response link
  input  ni_pkg::flit_t    rsp_flit_i,
  input  logic             rsp_valid_i,
  output logic             rsp_ready_o
);

  import ni_pkg::*;

  // Arbiter input 0 carries writes, input 1 reads
  flit_t [1:0] req_flit;
  logic  [1:0] req_valid;
  logic  [1:0] req_ready;
  logic        is_b;

  //////////////////////////////
  // Request packing
  //////////////////////////////

  always_comb begin
    req_flit[0].hdr.dst_id = wr_req_i.addr[NodeIdOffset +: NodeIdWidth];
    req_flit[0].hdr.src_id = id_i;
    req_flit[0].hdr.ch     = ChWr;
    req_flit[0].payload    = wr_req_i;

    req_flit[1].hdr.dst_id = rd_req_i.addr[NodeIdOffset +: NodeIdWidth];
    req_flit[1].hdr.src_id = id_i;
    req_flit[1].hdr.ch     = ChRd;
    req_flit[1].payload    = PayloadWidth'(rd_req_i);
  end

  assign req_valid  = {rd_valid_i, wr_valid_i};
  assign wr_ready_o = req_ready[0];
  assign rd_ready_o = req_ready[1];

  ni_rr_arbiter #(
    .Width ($bits(flit_t))
  ) i_req_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (req_valid),
    .ready_o (req_ready),
    .data_i  (req_flit),
    .valid_o (req_valid_o),
    .ready_i (req_ready_i),
    .data_o  (req_flit_o)
  );

  //////////////////////////////
  // Response unpacking
  //////////////////////////////

  // Anything that is not B goes to R
  assign is_b = rsp_flit_i.hdr.ch == ChB;

  assign b_rsp_o   = b_rsp_t'(rsp_flit_i.payload[$bits(b_rsp_t)-1:0]);
  assign r_rsp_o   = r_rsp_t'(rsp_flit_i.payload[$bits(r_rsp_t)-1:0]);
  assign b_valid_o = rsp_valid_i && is_b;
  assign r_valid_o = rsp_valid_i && !is_b;

  assign rsp_ready_o = is_b ? b_ready_i : r_ready_i;

  // The remote subordinate side only ever sends B and R on this link
  assert_rsp_channel : assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i |-> rsp_flit_i.hdr.ch inside {ChB, ChR});

endmodule

`default_nettype wire

//--- ni_sbr_side.sv
// Subordinate half of the network interface
// Memory must answer each channel in order, meta buffers are plain FIFOs
// At most MaxTxns transactions per channel wait for an answer
`timescale 1ns/1ps
`default_nettype none

module ni_sbr_side #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  ni_pkg::node_id_t id_i,
  // Inbound request link
  input  ni_pkg::flit_t    req_flit_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  // Memory requests
  output ni_pkg::mem_wr_t  mem_wr_o,
  output logic             mem_wr_valid_o,
  input  logic             mem_wr_ready_i,
  output ni_pkg::mem_rd_t  mem_rd_o,
  output logic             mem_rd_valid_o,
  input  logic             mem_rd_ready_i,
  // Memory responses
  input  ni_pkg::mem_b_t   mem_b_i,
  input  logic             mem_b_valid_i,
  output logic             mem_b_ready_o,
  input  ni_pkg::mem_r_t   mem_r_i,
  input  logic             mem_r_valid_i,
  output logic             mem_r_ready_o,
  // Outbound response link
  output ni_pkg::flit_t    rsp_flit_o,
  output logic             rsp_valid_o,
  input  logic             rsp_ready_i
);

  import ni_pkg::*;

  localparam int unsigned PtrWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  // Index 0 is the write and B path, index 1 the read and R path
  wr_req_t     wr_req;
  rd_req_t     rd_req;
  b_rsp_t      b_rsp;
  r_rsp_t      r_rsp;
  meta_t [1:0] push_meta, pop_meta;
  logic  [1:0] push, pop, full, empty;
  flit_t [1:0] rsp_flit;
  logic  [1:0] rsp_valid, rsp_ready;

  //////////////////////////////
  // Request unpacking
  //////////////////////////////

  assign wr_req = wr_req_t'(req_flit_i.payload);
  assign rd_req = rd_req_t'(req_flit_i.payload[$bits(rd_req_t)-1:0]);

  assign mem_wr_o = '{addr: wr_req.addr, data: wr_req.data};
  assign mem_rd_o = '{addr: rd_req.addr};

  // A request waits on the link while its meta buffer is full
  assign mem_wr_valid_o = req_valid_i && (req_flit_i.hdr.ch == ChWr) && !full[0];
  assign mem_rd_valid_o = req_valid_i && (req_flit_i.hdr.ch == ChRd) && !full[1];

  // Response codes have no business here and get dropped
  always_comb begin
    case (req_flit_i.hdr.ch)
      ChWr:    req_ready_o = mem_wr_ready_i && !full[0];
      ChRd:    req_ready_o = mem_rd_ready_i && !full[1];
      default: req_ready_o = 1'b1;
    endcase
  end

  assign push[0]      = mem_wr_valid_o && mem_wr_ready_i;
  assign push[1]      = mem_rd_valid_o && mem_rd_ready_i;
  assign push_meta[0] = '{id: wr_req.id, src_id: req_flit_i.hdr.src_id};
  assign push_meta[1] = '{id: rd_req.id, src_id: req_flit_i.hdr.src_id};

  //////////////////////////////
  // Meta buffers
  //////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : gen_meta_buf
    meta_t mem_q [MaxTxns];
    ptr_t  wr_ptr_q, rd_ptr_q;
    cnt_t  cnt_q;

    assign full[i]     = cnt_q == cnt_t'(MaxTxns);
    assign empty[i]    = cnt_q == '0;
    assign pop_meta[i] = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push[i]) begin
          wr_ptr_q <= (wr_ptr_q == ptr_t'(MaxTxns - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop[i]) begin
          rd_ptr_q <= (rd_ptr_q == ptr_t'(MaxTxns - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push[i] && !pop[i]) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (pop[i] && !push[i]) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (push[i]) begin
        mem_q[wr_ptr_q] <= push_meta[i];
      end
    end

    // A full buffer has wrapped its write pointer onto the read pointer
    assert_full_ptrs : assert property (@(posedge clk_i) disable iff (reset_i)
      full[i] |-> wr_ptr_q == rd_ptr_q);

    // Memory answers only what it was asked for
    assert_no_pop_empty : assert property (@(posedge clk_i) disable iff (reset_i)
      pop[i] |-> !empty[i]);
  end

  //////////////////////////////
  // Response packing
  //////////////////////////////

  // Pop and flit departure happen in the same cycle
  assign pop[0] = mem_b_valid_i && mem_b_ready_o;
  assign pop[1] = mem_r_valid_i && mem_r_ready_o;

  assign b_rsp = '{id: pop_meta[0].id, resp: mem_b_i.resp};
  assign r_rsp = '{id: pop_meta[1].id, data: mem_r_i.data, resp: mem_r_i.resp};

  always_comb begin
    rsp_flit[0].hdr     = '{dst_id: pop_meta[0].src_id, src_id: id_i, ch: ChB};
    rsp_flit[0].payload = PayloadWidth'(b_rsp);
    rsp_flit[1].hdr     = '{dst_id: pop_meta[1].src_id, src_id: id_i, ch: ChR};
    rsp_flit[1].payload = PayloadWidth'(r_rsp);
  end

  assign rsp_valid     = {mem_r_valid_i, mem_b_valid_i};
  assign mem_b_ready_o = rsp_ready[0];
  assign mem_r_ready_o = rsp_ready[1];

  ni_rr_arbiter #(
    .Width ($bits(flit_t))
  ) i_rsp_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (rsp_valid),
    .ready_o (rsp_ready),
    .data_i  (rsp_flit),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_flit_o)
  );

endmodule

`default_nettype wire

//--- axi_ni_top.sv
// Network interface with a local manager port, a local memory port
// and one request and one response link to the network
// Local requests and both inbound links are cut by spill registers
`timescale 1ns/1ps
`default_nettype none

module axi_ni_top #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  ni_pkg::node_id_t id_i,
  // Local manager port
  input  ni_pkg::wr_req_t  wr_req_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  input  ni_pkg::rd_req_t  rd_req_i,
  input  logic             rd_valid_i,
  output logic             rd_ready_o,
  output ni_pkg::b_rsp_t   b_rsp_o,
  output logic             b_valid_o,
  input  logic             b_ready_i,
  output ni_pkg::r_rsp_t   r_rsp_o,
  output logic             r_valid_o,
  input  logic             r_ready_i,
  // Local memory port
  output ni_pkg::mem_wr_t  mem_wr_o,
  output logic             mem_wr_valid_o,
  input  logic             mem_wr_ready_i,
  output ni_pkg::mem_rd_t  mem_rd_o,
  output logic             mem_rd_valid_o,
  input  logic             mem_rd_ready_i,
  input  ni_pkg::mem_b_t   mem_b_i,
  input  logic             mem_b_valid_i,
  output logic             mem_b_ready_o,
  input  ni_pkg::mem_r_t   mem_r_i,
  input  logic             mem_r_valid_i,
  output logic             mem_r_ready_o,
  // Outbound links
  output ni_pkg::flit_t    req_flit_o,
  output logic             req_valid_o,
  input  logic             req_ready_i,
  output ni_pkg::flit_t    rsp_flit_o,
  output logic             rsp_valid_o,
  input  logic             rsp_ready_i,
  // Inbound links
  input  ni_pkg::flit_t    req_flit_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  ni_pkg::flit_t    rsp_flit_i,
  input  logic             rsp_valid_i,
  output logic             rsp_ready_o
);

  import ni_pkg::*;

  // Spill register outputs seen by the two sides
  wr_req_t wr_req_sp;
  rd_req_t rd_req_sp;
  flit_t   req_flit_sp, rsp_flit_sp;
  logic    wr_valid_sp, wr_ready_sp, rd_valid_sp, rd_ready_sp;
  logic    req_valid_sp, req_ready_sp, rsp_valid_sp, rsp_ready_sp;

  //////////////////////////////
  // Spill registers
  //////////////////////////////

  ni_spill_reg #(.Width($bits(wr_req_t))) i_wr_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (wr_valid_i),
    .ready_o (wr_ready_o),
    .data_i  (wr_req_i),
    .valid_o (wr_valid_sp),
    .ready_i (wr_ready_sp),
    .data_o  (wr_req_sp)
  );

  ni_spill_reg #(.Width($bits(rd_req_t))) i_rd_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (rd_valid_i),
    .ready_o (rd_ready_o),
    .data_i  (rd_req_i),
    .valid_o (rd_valid_sp),
    .ready_i (rd_ready_sp),
    .data_o  (rd_req_sp)
  );

  ni_spill_reg #(.Width($bits(flit_t))) i_req_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_flit_i),
    .valid_o (req_valid_sp),
    .ready_i (req_ready_sp),
    .data_o  (req_flit_sp)
  );

  ni_spill_reg #(.Width($bits(flit_t))) i_rsp_spill (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (rsp_valid_i),
    .ready_o (rsp_ready_o),
    .data_i  (rsp_flit_i),
    .valid_o (rsp_valid_sp),
    .ready_i (rsp_ready_sp),
    .data_o  (rsp_flit_sp)
  );

  //////////////////////////////
  // Manager and subordinate
  //////////////////////////////

  ni_mgr_side i_mgr_side (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .id_i        (id_i),
    .wr_req_i    (wr_req_sp),
    .wr_valid_i  (wr_valid_sp),
    .wr_ready_o  (wr_ready_sp),
    .rd_req_i    (rd_req_sp),
    .rd_valid_i  (rd_valid_sp),
    .rd_ready_o  (rd_ready_sp),
    .b_rsp_o     (b_rsp_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .r_rsp_o     (r_rsp_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .req_flit_o  (req_flit_o),
    .req_valid_o (req_valid_o),
    .req_ready_i (req_ready_i),
    .rsp_flit_i  (rsp_flit_sp),
    .rsp_valid_i (rsp_valid_sp),
    .rsp_ready_o (rsp_ready_sp)
  );

  ni_sbr_side #(
    .MaxTxns (MaxTxns)
  ) i_sbr_side (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .id_i           (id_i),
    .req_flit_i     (req_flit_sp),
    .req_valid_i    (req_valid_sp),
    .req_ready_o    (req_ready_sp),
    .mem_wr_o       (mem_wr_o),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_ready_i (mem_wr_ready_i),
    .mem_rd_o       (mem_rd_o),
    .mem_rd_valid_o (mem_rd_valid_o),
    .mem_rd_ready_i (mem_rd_ready_i),
    .mem_b_i        (mem_b_i),
    .mem_b_valid_i  (mem_b_valid_i),
    .mem_b_ready_o  (mem_b_ready_o),
    .mem_r_i        (mem_r_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .rsp_flit_o     (rsp_flit_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_axi_ni.sv
// Testbench for axi_ni_top with both links looped back, so node 5 talks to itself
// Memory model has 16 words at address bits 5:2 and answers each channel in order
// Address bit 6 gives a slave error, such a write stores nothing and a read returns zero
`timescale 1ns/1ps
`default_nettype none

module tb_axi_ni;

  import ni_pkg::*;

  typedef logic [127:0] wide_t;

  localparam node_id_t NodeId  = 4'd5;
  localparam int       Timeout = 5000;

  logic clk_i = 1'b0;
  logic reset_i;
  wr_req_t wr_req_i;
  logic wr_valid_i, wr_ready_o, rd_valid_i, rd_ready_o;
  rd_req_t rd_req_i;
  b_rsp_t b_rsp_o;
  r_rsp_t r_rsp_o;
  logic b_valid_o, b_ready_i, r_valid_o, r_ready_i;
  mem_wr_t mem_wr_o;
  mem_rd_t mem_rd_o;
  mem_b_t mem_b_i;
  mem_r_t mem_r_i;
  logic mem_wr_valid_o, mem_wr_ready_i, mem_rd_valid_o, mem_rd_ready_i;
  logic mem_b_valid_i, mem_b_ready_o, mem_r_valid_i, mem_r_ready_o;
  flit_t req_flit_o, rsp_flit_o, req_flit_i, rsp_flit_i;
  logic req_valid_o, req_ready_i, rsp_valid_o, rsp_ready_i;
  logic req_valid_i, req_ready_o, rsp_valid_i, rsp_ready_o;
  logic req_stall, rsp_stall, stress;

  // Expected traffic, filled when a local request is accepted
  flit_t  exp_wr_flit_q [$];
  flit_t  exp_rd_flit_q [$];
  b_rsp_t exp_b_q [$];
  r_rsp_t exp_r_q [$];
  wr_req_t wr_plan [$];
  rd_req_t rd_plan [$];

  data_t  mem [16];
  data_t  ref_mem [16];
  mem_b_t b_pipe [$];
  mem_r_t r_pipe [$];
  logic   b_fired, r_fired;
  logic [31:0] rng_state = 32'd4975;
  int     errors, checks, tests, failed_tests, b_seen, r_seen;
  string  test_name;

  always #10 clk_i = ~clk_i;

  axi_ni_top #(.MaxTxns(4)) uut (.*, .id_i(NodeId));

  // Loopback links, one stall bit per link freezes both directions
  assign req_flit_i  = req_flit_o;
  assign req_valid_i = req_valid_o && !req_stall;
  assign req_ready_i = req_ready_o && !req_stall;
  assign rsp_flit_i  = rsp_flit_o;
  assign rsp_valid_i = rsp_valid_o && !rsp_stall;
  assign rsp_ready_i = rsp_ready_o && !rsp_stall;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // High on three cycles out of four under stress, always high otherwise
  function automatic logic random_go();
    logic [31:0] x;
    x = next_random();
    return !stress || (x[1:0] != 2'b00);
  endfunction

  function automatic data_t fill_word(input int idx);
    return 32'h9E37_79B9 * (idx + 1);
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic b_rsp_t expect_b(input wr_req_t req);
    b_rsp_t b;
    b.id   = req.id;
    b.resp = req.addr[6] ? RespSlvErr : RespOkay;
    return b;
  endfunction

  function automatic r_rsp_t expect_r(input rd_req_t req);
    r_rsp_t r;
    r.id   = req.id;
    r.resp = req.addr[6] ? RespSlvErr : RespOkay;
    r.data = req.addr[6] ? '0 : ref_mem[req.addr[5:2]];
    return r;
  endfunction

  task automatic check_value(input string name, input wide_t exp, input wide_t act);
    checks++;
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always @(posedge clk_i) begin
    b_fired = mem_b_valid_i && mem_b_ready_o;
    r_fired = mem_r_valid_i && mem_r_ready_o;
    if (b_fired) begin
      b_pipe.delete(0);
    end
    if (r_fired) begin
      r_pipe.delete(0);
    end
    if (mem_wr_valid_o && mem_wr_ready_i) begin
      if (!mem_wr_o.addr[6]) begin
        mem[mem_wr_o.addr[5:2]] = mem_wr_o.data;
      end
      b_pipe.push_back('{resp: mem_wr_o.addr[6] ? RespSlvErr : RespOkay});
    end
    if (mem_rd_valid_o && mem_rd_ready_i) begin
      r_pipe.push_back('{data: mem_rd_o.addr[6] ? '0 : mem[mem_rd_o.addr[5:2]],
                         resp: mem_rd_o.addr[6] ? RespSlvErr : RespOkay});
    end
  end

  // Readies and stalls are free, a response valid holds until taken
  always @(negedge clk_i) begin
    b_ready_i      = random_go();
    r_ready_i      = random_go();
    mem_wr_ready_i = random_go();
    mem_rd_ready_i = random_go();
    req_stall      = !random_go();
    rsp_stall      = !random_go();
    if (!mem_b_valid_i || b_fired) begin
      mem_b_valid_i = (b_pipe.size() > 0) && random_go();
      mem_b_i       = (b_pipe.size() > 0) ? b_pipe[0] : '0;
    end
    if (!mem_r_valid_i || r_fired) begin
      mem_r_valid_i = (r_pipe.size() > 0) && random_go();
      mem_r_i       = (r_pipe.size() > 0) ? r_pipe[0] : '0;
    end
  end

  //////////////////////////////
  // Monitors
  //////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (req_valid_o && req_ready_i) begin
        if (req_flit_o.hdr.ch == ChWr && exp_wr_flit_q.size() > 0) begin
          check_value({test_name, " write flit"}, wide_t'(exp_wr_flit_q.pop_front()),
                      wide_t'(req_flit_o));
        end else if (req_flit_o.hdr.ch == ChRd && exp_rd_flit_q.size() > 0) begin
          check_value({test_name, " read flit"}, wide_t'(exp_rd_flit_q.pop_front()),
                      wide_t'(req_flit_o));
        end else begin
          $display("%s: request flit %h left with no matching request", test_name, req_flit_o);
          errors++;
        end
      end
      // Every request came from this node, so every answer goes back to it
      if (rsp_valid_o && rsp_ready_i) begin
        check_value({test_name, " response flit dst_id"}, wide_t'(NodeId),
                    wide_t'(rsp_flit_o.hdr.dst_id));
        check_value({test_name, " response flit src_id"}, wide_t'(NodeId),
                    wide_t'(rsp_flit_o.hdr.src_id));
      end
      if (b_valid_o && b_ready_i) begin
        b_seen++;
        if (exp_b_q.size() == 0) begin
          $display("%s: B response %h arrived with none outstanding", test_name, b_rsp_o);
          errors++;
        end else begin
          check_value({test_name, " B"}, wide_t'(exp_b_q.pop_front()), wide_t'(b_rsp_o));
        end
      end
      if (r_valid_o && r_ready_i) begin
        r_seen++;
        if (exp_r_q.size() == 0) begin
          $display("%s: R response %h arrived with none outstanding", test_name, r_rsp_o);
          errors++;
        end else begin
          check_value({test_name, " R"}, wide_t'(exp_r_q.pop_front()), wide_t'(r_rsp_o));
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // Called on a falling edge, returns on a falling edge
  task automatic send_write(input wr_req_t req);
    int   n;
    logic taken;
    flit_t f;
    n          = 0;
    taken      = 1'b0;
    f.hdr      = '{dst_id: req.addr[31:28], src_id: NodeId, ch: ChWr};
    f.payload  = req;
    wr_req_i   = req;
    wr_valid_i = 1'b1;
    while (!taken && n < Timeout) begin
      @(posedge clk_i);
      taken = wr_ready_o;
      n++;
    end
    if (taken) begin
      exp_wr_flit_q.push_back(f);
      exp_b_q.push_back(expect_b(req));
      if (!req.addr[6]) begin
        ref_mem[req.addr[5:2]] = req.data;
      end
    end else begin
      $display("%s: write request was never accepted", test_name);
      errors++;
    end
    @(negedge clk_i);
    wr_valid_i = 1'b0;
  endtask

  task automatic send_read(input rd_req_t req);
    int   n;
    logic taken;
    flit_t f;
    n          = 0;
    taken      = 1'b0;
    f.hdr      = '{dst_id: req.addr[31:28], src_id: NodeId, ch: ChRd};
    f.payload  = {32'd0, req};
    rd_req_i   = req;
    rd_valid_i = 1'b1;
    while (!taken && n < Timeout) begin
      @(posedge clk_i);
      taken = rd_ready_o;
      n++;
    end
    if (taken) begin
      exp_rd_flit_q.push_back(f);
      exp_r_q.push_back(expect_r(req));
    end else begin
      $display("%s: read request was never accepted", test_name);
      errors++;
    end
    @(negedge clk_i);
    rd_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    int n;
    n = 0;
    while ((exp_b_q.size() + exp_r_q.size() + exp_wr_flit_q.size() + exp_rd_flit_q.size()) > 0
           && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= Timeout) begin
      $display("%s: responses still outstanding after %0d cycles", test_name, Timeout);
      errors++;
    end
  endtask

  task automatic send_plans();
    fork
      begin
        foreach (wr_plan[i]) send_write(wr_plan[i]);
      end
      begin
        foreach (rd_plan[i]) send_read(rd_plan[i]);
      end
    join
    wait_responses();
    wr_plan.delete();
    rd_plan.delete();
  endtask

  task automatic finish_test(input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: failed", test_name);
    end
  endtask

  initial begin
    int base, nb, nr;
    logic [31:0] x;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    b_seen = 0;
    r_seen = 0;
    stress = 1'b0;
    reset_i = 1'b1;
    wr_req_i = '0;
    rd_req_i = '0;
    wr_valid_i = 1'b0;
    rd_valid_i = 1'b0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    mem_wr_ready_i = 1'b1;
    mem_rd_ready_i = 1'b1;
    mem_b_valid_i = 1'b0;
    mem_r_valid_i = 1'b0;
    mem_b_i = '0;
    mem_r_i = '0;
    req_stall = 1'b0;
    rsp_stall = 1'b0;
    b_fired = 1'b0;
    r_fired = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_name = "reset";
    base = errors;
    check_value({test_name, " valid outputs"}, '0, wide_t'({b_valid_o, r_valid_o,
                mem_wr_valid_o, mem_rd_valid_o, req_valid_o, rsp_valid_o}));
    finish_test(base);

    test_name = "write_then_read";
    base = errors;
    send_write('{addr: 32'h1000_000C, data: 32'hCAFE_F00D, id: 4'd3});
    wait_responses();
    send_read('{addr: 32'h1000_000C, id: 4'd9});
    wait_responses();
    finish_test(base);

    test_name = "flit_headers";
    base = errors;
    for (int k = 0; k < 16; k++) begin
      if (k % 2 == 0) begin
        send_write('{addr: {4'(k), 22'd0, 4'(k), 2'b00}, data: next_random(), id: 4'(k)});
      end else begin
        send_read('{addr: {4'(k), 22'd0, 4'(k), 2'b00}, id: 4'(k)});
      end
    end
    wait_responses();
    finish_test(base);

    // Writes hit words 0 to 7 and reads words 8 to 15, so order between them is free
    test_name = "both_channels";
    base = errors;
    for (int i = 0; i < 8; i++) begin
      wr_plan.push_back('{addr: {4'(i), 22'd0, 4'(i), 2'b00}, data: next_random(), id: 4'(i)});
      rd_plan.push_back('{addr: {4'(15 - i), 22'd0, 4'(8 + i), 2'b00}, id: 4'(8 + i)});
    end
    send_plans();
    finish_test(base);

    test_name = "random_backpressure";
    base = errors;
    nb = b_seen;
    nr = r_seen;
    for (int i = 0; i < 12; i++) begin
      x = next_random();
      wr_plan.push_back('{addr: {x[31:28], x[26:6], 2'b00, x[2:0], 2'b00},
                          data: next_random(), id: x[7:4]});
      x = next_random();
      rd_plan.push_back('{addr: {x[31:28], x[26:6], 2'b01, x[2:0], 2'b00}, id: x[7:4]});
    end
    stress = 1'b1;
    send_plans();
    stress = 1'b0;
    check_value({test_name, " B response count"}, wide_t'(12), wide_t'(b_seen - nb));
    check_value({test_name, " R response count"}, wide_t'(12), wide_t'(r_seen - nr));
    finish_test(base);

    test_name = "slave_error";
    base = errors;
    send_write('{addr: 32'h2000_0048, data: 32'h1234_5678, id: 4'd12});
    send_read('{addr: 32'h2000_0048, id: 4'd13});
    wait_responses();
    finish_test(base);

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks,
             errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
ni_pkg.sv
ni_spill_reg.sv
ni_rr_arbiter.sv
ni_mgr_side.sv
ni_sbr_side.sv
axi_ni_top.sv
tb_axi_ni.sv

//--- Makefile
# Verilator build and run of the network interface testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_axi_ni
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the outcome, not the simulator exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
